// ==== Makefile ====
TOP := eth_mgmt_tb

.PHONY: all build lint clean

all: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f src.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== source/axil_reg_port.sv ====
//==========================================================================
// AXI-Lite slave port, turns bus transfers into single register accesses
//==========================================================================
`default_nettype none

module axil_reg_port
    import eth_mgmt_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  axil_req_t         bus_i,
    output axil_rsp_t         bus_o,
    output reg_access_t       access_o,
    input  logic [DATA_W-1:0] rdata_i
);

    logic rd_pend;
    logic aw_pend;
    logic w_pend;
    logic rd_strobe;
    logic wr_strobe;
    logic r_valid;
    logic b_valid;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic [DATA_W-1:0] r_data;
    logic ar_ready;
    logic aw_ready;
    logic w_ready;
    logic ar_fire;
    logic aw_fire;
    logic w_fire;
    logic wr_go;
    logic rd_go;

    // No new address while a request or its response is outstanding
    assign ar_ready = !rd_pend && !r_valid;
    assign aw_ready = !aw_pend && !b_valid;
    assign w_ready = !w_pend && !b_valid;

    assign ar_fire = ar_ready && bus_i.ar_valid;
    assign aw_fire = aw_ready && bus_i.aw_valid;
    assign w_fire = w_ready && bus_i.w_valid;

    // Writes win when both sides are ready in the same cycle
    assign wr_go = aw_pend && w_pend;
    assign rd_go = rd_pend && !rd_strobe && !wr_go;

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_pend <= 1'b0;
            aw_pend <= 1'b0;
            w_pend <= 1'b0;
            rd_strobe <= 1'b0;
            wr_strobe <= 1'b0;
            r_valid <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            rd_strobe <= rd_go;
            wr_strobe <= wr_go;
            if (ar_fire) begin
                rd_pend <= 1'b1;
            end else if (rd_strobe) begin
                rd_pend <= 1'b0;
            end
            if (aw_fire) begin
                aw_pend <= 1'b1;
            end else if (wr_go) begin
                aw_pend <= 1'b0;
            end
            if (w_fire) begin
                w_pend <= 1'b1;
            end else if (wr_go) begin
                w_pend <= 1'b0;
            end
            if (rd_strobe) begin
                r_valid <= 1'b1;
            end else if (bus_i.r_ready) begin
                r_valid <= 1'b0;
            end
            if (wr_go) begin
                b_valid <= 1'b1;
            end else if (bus_i.b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    // Captured address and data stay put until the response completes
    always_ff @(posedge clock) begin
        if (ar_fire) begin
            rd_addr <= bus_i.ar_addr;
        end
        if (aw_fire) begin
            wr_addr <= bus_i.aw_addr;
        end
        if (w_fire) begin
            wr_data <= bus_i.w_data;
        end
        if (rd_strobe) begin
            r_data <= rdata_i;
        end
    end

    always_comb begin
        access_o.rd = rd_strobe;
        access_o.wr = wr_strobe;
        access_o.addr = wr_strobe ? wr_addr : rd_addr;
        access_o.wdata = wr_data;

        bus_o.aw_ready = aw_ready;
        bus_o.w_ready = w_ready;
        bus_o.b_valid = b_valid;
        bus_o.b_resp = AXI_RESP_OKAY;
        bus_o.ar_ready = ar_ready;
        bus_o.r_valid = r_valid;
        bus_o.r_data = r_data;
        bus_o.r_resp = AXI_RESP_OKAY;
    end

endmodule

`default_nettype wire

// ==== source/eth_mgmt_pkg.sv ====
//==========================================================================
// Ethernet management package: register map, bus structs, MDIO frame
//==========================================================================
`default_nettype none

package eth_mgmt_pkg;

    localparam int REG_ADDR_W = 12;
    localparam int DATA_W = 32;

    // MDIO clock half period in system clocks
    localparam int MDIO_HALF_CYCLES = 25;
    localparam int MDIO_DIV_W = $clog2(MDIO_HALF_CYCLES);
    localparam int MDIO_PREAMBLE_BITS = 32;

    localparam logic [REG_ADDR_W-1:0] REG_STATUS = 12'h000;
    localparam logic [REG_ADDR_W-1:0] REG_INT_ENABLE = 12'h008;
    localparam logic [REG_ADDR_W-1:0] REG_INT_STATUS = 12'h00C;
    localparam logic [REG_ADDR_W-1:0] REG_CONTROL = 12'h020;
    localparam logic [REG_ADDR_W-1:0] REG_MDIO_TX = 12'h024;
    localparam logic [REG_ADDR_W-1:0] REG_MDIO_RX = 12'h028;

    localparam int INT_BIT_MDIO_IDLE = 16;
    localparam int INT_BIT_PHY = 17;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // PCS/PMA status vector, bit 15 first
    typedef struct packed {
        logic [1:0] pause;
        logic       remote_fault;
        logic       duplex;
        logic [1:0] speed;
        logic [1:0] remote_fault_encdg;
        logic       phy_link;
        logic       rx_not_in_table;
        logic       rx_disp_err;
        logic       rudi_invalid;
        logic       rudi_i;
        logic       rudi_c;
        logic       link_sync;
        logic       link_status;
    } pcs_status_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] aw_addr;
        logic                  aw_valid;
        logic [DATA_W-1:0]     w_data;
        logic                  w_valid;
        logic                  b_ready;
        logic [REG_ADDR_W-1:0] ar_addr;
        logic                  ar_valid;
        logic                  r_ready;
    } axil_req_t;

    typedef struct packed {
        logic              aw_ready;
        logic              w_ready;
        logic              b_valid;
        logic [1:0]        b_resp;
        logic              ar_ready;
        logic              r_valid;
        logic [DATA_W-1:0] r_data;
        logic [1:0]        r_resp;
    } axil_rsp_t;

    // One register access, strobes last a single cycle
    typedef struct packed {
        logic                  rd;
        logic                  wr;
        logic [REG_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     wdata;
    } reg_access_t;

    typedef struct packed {
        logic [1:0]  start;
        logic [1:0]  op;
        logic [4:0]  phy_addr;
        logic [4:0]  reg_addr;
        logic [1:0]  ta;
        logic [15:0] data;
    } mdio_fields_t;

    // Raw word for the shifter, fields for the op decode
    typedef union packed {
        logic [DATA_W-1:0] raw;
        mdio_fields_t      fields;
    } mdio_frame_u;

    typedef struct packed {
        logic        start;
        mdio_frame_u frame;
    } mdio_cmd_t;

endpackage

`default_nettype wire

// ==== source/eth_mgmt_top.sv ====
//==========================================================================
// Ethernet management top: AXI-Lite port, registers and MDIO master
//==========================================================================
`default_nettype none

module eth_mgmt_top
    import eth_mgmt_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  axil_req_t   bus_i,
    output axil_rsp_t   bus_o,
    input  pcs_status_t status_i,
    input  logic        phy_int_i,
    output logic        irq_o,
    output logic        phy_reset_o,
    output logic        mdc_o,
    output logic        mdio_o,
    output logic        mdio_oe_o,
    input  logic        mdio_i
);

    reg_access_t access;
    logic [DATA_W-1:0] rdata;
    mdio_cmd_t mdio_cmd;
    logic mdio_done;
    logic [DATA_W-1:0] mdio_rx;

    axil_reg_port axil_reg_port_i (
        .clock    (clock),
        .reset    (reset),
        .bus_i    (bus_i),
        .bus_o    (bus_o),
        .access_o (access),
        .rdata_i  (rdata)
    );

    mgmt_regs mgmt_regs_i (
        .clock       (clock),
        .reset       (reset),
        .access_i    (access),
        .rdata_o     (rdata),
        .status_i    (status_i),
        .phy_int_i   (phy_int_i),
        .mdio_done_i (mdio_done),
        .mdio_rx_i   (mdio_rx),
        .mdio_cmd_o  (mdio_cmd),
        .phy_reset_o (phy_reset_o),
        .irq_o       (irq_o)
    );

    mdio_master mdio_master_i (
        .clock     (clock),
        .reset     (reset),
        .cmd_i     (mdio_cmd),
        .done_o    (mdio_done),
        .rx_data_o (mdio_rx),
        .mdc_o     (mdc_o),
        .mdio_o    (mdio_o),
        .mdio_oe_o (mdio_oe_o),
        .mdio_i    (mdio_i)
    );

endmodule

`default_nettype wire

// ==== source/mdio_master.sv ====
//==========================================================================
// MDIO master, shifts preamble and one 32-bit frame, captures the reply
//==========================================================================
`default_nettype none

module mdio_master
    import eth_mgmt_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  mdio_cmd_t         cmd_i,
    output logic              done_o,
    output logic [DATA_W-1:0] rx_data_o,
    output logic              mdc_o,
    output logic              mdio_o,
    output logic              mdio_oe_o,
    input  logic              mdio_i
);

    logic active;
    logic tail;
    logic done_q;
    logic mdc_q;
    logic line_o_q;
    logic line_oe_q;
    logic [MDIO_DIV_W-1:0] div_cnt;
    logic [5:0] bit_cnt;
    logic [DATA_W-1:0] rx_shift;
    logic half_end;
    logic last_bit;
    logic [5:0] next_idx;
    logic [4:0] frame_pos;
    logic next_o;
    logic next_oe;

    assign half_end = div_cnt == MDIO_DIV_W'(MDIO_HALF_CYCLES - 1);
    assign last_bit = bit_cnt == 6'(MDIO_PREAMBLE_BITS + DATA_W - 1);

    // Line value and direction for the bit about to be driven
    always_comb begin
        next_idx = active ? bit_cnt + 6'd1 : 6'd0;
        frame_pos = ~next_idx[4:0];
        if (next_idx < 6'(MDIO_PREAMBLE_BITS)) begin
            next_o = 1'b1;
            next_oe = 1'b1;
        end else begin
            next_o = cmd_i.frame.raw[frame_pos];
            // Read op hands the line to the PHY from turnaround on
            next_oe = !(cmd_i.frame.fields.op[1] && frame_pos <= 5'd17);
        end
    end

    always_ff @(posedge clock) begin
        if (reset || !cmd_i.start) begin
            active <= 1'b0;
            tail <= 1'b0;
            done_q <= 1'b0;
            mdc_q <= 1'b0;
            line_o_q <= 1'b1;
            line_oe_q <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else if (!active && !done_q) begin
            // Launch with the first preamble bit
            active <= 1'b1;
            mdc_q <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            line_o_q <= next_o;
            line_oe_q <= next_oe;
        end else if (active) begin
            if (!half_end) begin
                div_cnt <= div_cnt + MDIO_DIV_W'(1);
            end else begin
                div_cnt <= '0;
                if (tail) begin
                    active <= 1'b0;
                    tail <= 1'b0;
                    done_q <= 1'b1;
                end else if (!mdc_q) begin
                    mdc_q <= 1'b1;
                end else begin
                    mdc_q <= 1'b0;
                    if (last_bit) begin
                        // One idle half period after the last bit
                        tail <= 1'b1;
                        line_o_q <= 1'b1;
                        line_oe_q <= 1'b0;
                    end else begin
                        bit_cnt <= next_idx;
                        line_o_q <= next_o;
                        line_oe_q <= next_oe;
                    end
                end
            end
        end
    end

    // Sample the line on rising MDC during the frame part
    always_ff @(posedge clock) begin
        if (active && !tail && half_end && !mdc_q &&
            bit_cnt >= 6'(MDIO_PREAMBLE_BITS)) begin
            rx_shift <= {rx_shift[DATA_W-2:0], mdio_i};
        end
    end

    assign done_o = done_q;
    assign rx_data_o = rx_shift;
    assign mdc_o = mdc_q;
    assign mdio_o = line_o_q;
    assign mdio_oe_o = line_oe_q;

endmodule

`default_nettype wire

// ==== source/mgmt_regs.sv ====
//==========================================================================
// Management registers, interrupt logic and MDIO command launch
//==========================================================================
`default_nettype none

module mgmt_regs
    import eth_mgmt_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  reg_access_t       access_i,
    output logic [DATA_W-1:0] rdata_o,
    input  pcs_status_t       status_i,
    input  logic              phy_int_i,
    input  logic              mdio_done_i,
    input  logic [DATA_W-1:0] mdio_rx_i,
    output mdio_cmd_t         mdio_cmd_o,
    output logic              phy_reset_o,
    output logic              irq_o
);

    logic [DATA_W-1:0] int_enable;
    logic [DATA_W-1:0] int_status;
    logic phy_run;
    logic mdio_start;
    mdio_frame_u mdio_tx;
    logic [DATA_W-1:0] mdio_rx;
    logic [2:0] phy_int_sync;
    logic mdio_ack;

    assign mdio_ack = mdio_start && mdio_done_i;

    // PHY interrupt pin is asynchronous
    always_ff @(posedge clock) begin
        if (reset) begin
            phy_int_sync <= '0;
        end else begin
            phy_int_sync <= {phy_int_sync[1:0], phy_int_i};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            int_enable <= '0;
            phy_run <= 1'b0;
            mdio_start <= 1'b0;
        end else begin
            if (access_i.wr) begin
                case (access_i.addr)
                    REG_INT_ENABLE: int_enable <= access_i.wdata;
                    REG_CONTROL: phy_run <= access_i.wdata[0];
                    REG_MDIO_TX: mdio_start <= 1'b1;
                    default: ;
                endcase
            end
            // Engine handshake, start drops once done is seen
            if (mdio_ack) begin
                mdio_start <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (access_i.wr && access_i.addr == REG_MDIO_TX) begin
            mdio_tx.raw <= access_i.wdata;
        end
        if (mdio_ack) begin
            mdio_rx <= mdio_rx_i;
        end
    end

    always_comb begin
        int_status = '0;
        int_status[$bits(pcs_status_t)-1:0] = status_i;
        int_status[INT_BIT_MDIO_IDLE] = !mdio_start;
        int_status[INT_BIT_PHY] = phy_int_sync[2];
    end

    assign irq_o = |(int_enable & int_status);
    assign phy_reset_o = !phy_run;

    always_comb begin
        mdio_cmd_o.start = mdio_start;
        mdio_cmd_o.frame = mdio_tx;
    end

    // Read mux, unmapped addresses return zero
    always_comb begin
        rdata_o = '0;
        if (access_i.rd) begin
            case (access_i.addr)
                REG_STATUS: rdata_o[$bits(pcs_status_t)-1:0] = status_i;
                REG_INT_ENABLE: rdata_o = int_enable;
                REG_INT_STATUS: rdata_o = int_status;
                REG_CONTROL: rdata_o[0] = phy_run;
                REG_MDIO_TX: rdata_o = mdio_tx.raw;
                REG_MDIO_RX: rdata_o = mdio_rx;
                default: rdata_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
source/eth_mgmt_pkg.sv
source/axil_reg_port.sv
source/mgmt_regs.sv
source/mdio_master.sv
source/eth_mgmt_top.sv
tb/eth_mgmt_sva.sv
tb/eth_mgmt_tb.sv

// ==== tb/eth_mgmt_sva.sv ====
//==========================================================================
// Bound checks on AXI-Lite response hold and the MDIO handshake
//==========================================================================
`default_nettype none

module eth_mgmt_sva
    import eth_mgmt_pkg::*;
(
    input logic      clock,
    input logic      reset,
    input axil_req_t bus_req_i,
    input axil_rsp_t bus_rsp_i,
    input logic      mdio_oe_i,
    input logic      start_i,
    input logic      done_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // Responses stay up, with stable data, until the master takes them
    r_valid_hold: assert property (@(posedge clock) disable iff (reset)
        bus_rsp_i.r_valid && !bus_req_i.r_ready |=>
            bus_rsp_i.r_valid && $stable(bus_rsp_i.r_data))
        else begin
            $error("r_valid or r_data changed before r_ready");
            fail_count++;
        end

    b_valid_hold: assert property (@(posedge clock) disable iff (reset)
        bus_rsp_i.b_valid && !bus_req_i.b_ready |=> bus_rsp_i.b_valid)
        else begin
            $error("b_valid dropped before b_ready");
            fail_count++;
        end

    line_idle: assert property (@(posedge clock) disable iff (reset)
        !start_i |-> !mdio_oe_i)
        else begin
            $error("mdio_oe_o high with no MDIO command");
            fail_count++;
        end

    // Engine leaves done one cycle after start drops
    done_release: assert property (@(posedge clock) disable iff (reset)
        done_i && !start_i |=> !done_i)
        else begin
            $error("MDIO done held after start fell");
            fail_count++;
        end

endmodule

bind eth_mgmt_top eth_mgmt_sva eth_mgmt_sva_i (
    .clock     (clock),
    .reset     (reset),
    .bus_req_i (bus_i),
    .bus_rsp_i (bus_o),
    .mdio_oe_i (mdio_oe_o),
    .start_i   (mdio_cmd.start),
    .done_i    (mdio_done)
);

`default_nettype wire

// ==== tb/eth_mgmt_tb.sv ====
//==========================================================================
// Ethernet management testbench with AXI-Lite driver, PHY model and checks
//==========================================================================
`default_nettype none

module eth_mgmt_tb
    import eth_mgmt_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 200;
    localparam int POLL_LIMIT = 2000;

    logic clock;
    logic reset;
    axil_req_t bus_req;
    axil_rsp_t bus_rsp;
    pcs_status_t status;
    logic phy_int;
    logic irq;
    logic phy_reset;
    logic mdc;
    logic mdio_out;
    logic mdio_oe;
    logic mdio_in = 1'b1;

    int error_count = 0;
    int timeout_count = 0;
    int frame_id = 0;
    int frame_seen = 0;
    int phy_edges = 0;
    logic [63:0] phy_bits = '0;
    logic [15:0] phy_reply = '0;
    logic mdc_last = 1'b0;

    eth_mgmt_top eth_mgmt_top_i (
        .clock       (clock),
        .reset       (reset),
        .bus_i       (bus_req),
        .bus_o       (bus_rsp),
        .status_i    (status),
        .phy_int_i   (phy_int),
        .irq_o       (irq),
        .phy_reset_o (phy_reset),
        .mdc_o       (mdc),
        .mdio_o      (mdio_out),
        .mdio_oe_o   (mdio_oe),
        .mdio_i      (mdio_in)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // PHY model records each line bit at rising MDC
    always @(negedge clock) begin
        int pos;
        if (frame_id != frame_seen) begin
            phy_edges = 0;
            phy_bits = '0;
            frame_seen = frame_id;
        end
        if (mdc && !mdc_last) begin
            phy_bits = {phy_bits[62:0], mdio_in};
            phy_edges = phy_edges + 1;
        end
        mdc_last = mdc;
        pos = mdc ? phy_edges - 1 : phy_edges;
        if (mdio_oe) begin
            mdio_in = mdio_out;
        end else if (pos == 46) begin
            mdio_in = 1'b1;
        end else if (pos == 47) begin
            mdio_in = 1'b0;
        end else if (pos >= 48 && pos <= 63) begin
            mdio_in = phy_reply[4'(63 - pos)];
        end else begin
            mdio_in = 1'b1;
        end
    end

    task automatic bus_write(input logic [REG_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        int cycles;
        logic aw_hit;
        logic w_hit;
        bus_req.aw_addr = addr;
        bus_req.aw_valid = 1'b1;
        bus_req.w_data = data;
        bus_req.w_valid = 1'b1;
        cycles = 0;
        while ((bus_req.aw_valid || bus_req.w_valid) && cycles < WAIT_LIMIT) begin
            aw_hit = bus_rsp.aw_ready;
            w_hit = bus_rsp.w_ready;
            @(negedge clock);
            if (aw_hit) begin
                bus_req.aw_valid = 1'b0;
            end
            if (w_hit) begin
                bus_req.w_valid = 1'b0;
            end
            cycles++;
        end
        if (bus_req.aw_valid || bus_req.w_valid) begin
            $display("Timeout: write to %h was never accepted", addr);
            timeout_count++;
            bus_req.aw_valid = 1'b0;
            bus_req.w_valid = 1'b0;
        end
        cycles = 0;
        while (!bus_rsp.b_valid && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!bus_rsp.b_valid) begin
            $display("Timeout: no write response for address %h", addr);
            timeout_count++;
        end else begin
            if (bus_rsp.b_resp !== 2'b00) begin
                $display("[ERROR] %0t: b_resp = %b, expected 00", $time, bus_rsp.b_resp);
                error_count++;
            end
            bus_req.b_ready = 1'b1;
            @(negedge clock);
            bus_req.b_ready = 1'b0;
        end
    endtask

    task automatic bus_read(input logic [REG_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        int cycles;
        logic ar_hit;
        data = 'x;
        bus_req.ar_addr = addr;
        bus_req.ar_valid = 1'b1;
        cycles = 0;
        while (bus_req.ar_valid && cycles < WAIT_LIMIT) begin
            ar_hit = bus_rsp.ar_ready;
            @(negedge clock);
            if (ar_hit) begin
                bus_req.ar_valid = 1'b0;
            end
            cycles++;
        end
        if (bus_req.ar_valid) begin
            $display("Timeout: read of %h was never accepted", addr);
            timeout_count++;
            bus_req.ar_valid = 1'b0;
        end
        cycles = 0;
        while (!bus_rsp.r_valid && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!bus_rsp.r_valid) begin
            $display("Timeout: no read data for address %h", addr);
            timeout_count++;
        end else begin
            data = bus_rsp.r_data;
            if (bus_rsp.r_resp !== 2'b00) begin
                $display("[ERROR] %0t: r_resp = %b, expected 00", $time, bus_rsp.r_resp);
                error_count++;
            end
            bus_req.r_ready = 1'b1;
            @(negedge clock);
            bus_req.r_ready = 1'b0;
        end
    endtask

    // Runs one MDIO frame and polls the idle bit until it ends
    task automatic run_mdio(input logic [31:0] frame, input logic [15:0] reply,
                            input logic [31:0] exp_rx);
        logic [31:0] value;
        int polls;
        phy_reply = reply;
        frame_id = frame_id + 1;
        bus_write(REG_MDIO_TX, frame);
        value = '0;
        polls = 0;
        while (value[INT_BIT_MDIO_IDLE] !== 1'b1 && polls < POLL_LIMIT) begin
            bus_read(REG_INT_STATUS, value);
            polls++;
        end
        if (value[INT_BIT_MDIO_IDLE] !== 1'b1) begin
            $display("Timeout: MDIO frame %h never finished", frame);
            timeout_count++;
        end else begin
            if (phy_edges != 64) begin
                $display("[ERROR] %0t: mdc_o rising edges = %0d, expected 64", $time, phy_edges);
                error_count++;
            end
            if (phy_bits !== {32'hffff_ffff, exp_rx}) begin
                $display("[ERROR] %0t: mdio line bits = %h, expected %h", $time, phy_bits,
                         {32'hffff_ffff, exp_rx});
                error_count++;
            end
            bus_read(REG_MDIO_RX, value);
            if (value !== exp_rx) begin
                $display("[ERROR] %0t: mdio rx = %h, expected %h", $time, value, exp_rx);
                error_count++;
            end
        end
    endtask

    task automatic run_command(input int op, input logic [31:0] a, input logic [31:0] b,
                               input logic [31:0] c);
        logic [31:0] value;
        case (op)
            1: bus_write(a[REG_ADDR_W-1:0], b);
            2: begin
                bus_read(a[REG_ADDR_W-1:0], value);
                if (value !== b) begin
                    $display("[ERROR] %0t: r_data at %h = %h, expected %h", $time,
                             a[REG_ADDR_W-1:0], value, b);
                    error_count++;
                end
            end
            3: begin
                status = a[15:0];
                @(negedge clock);
            end
            // Synchronizer needs three clocks
            4: begin
                phy_int = a[0];
                repeat (4) @(negedge clock);
            end
            5: if (irq !== a[0]) begin
                $display("[ERROR] %0t: irq_o = %b, expected %b", $time, irq, a[0]);
                error_count++;
            end
            6: if (phy_reset !== a[0]) begin
                $display("[ERROR] %0t: phy_reset_o = %b, expected %b", $time, phy_reset, a[0]);
                error_count++;
            end
            7: run_mdio(a, b[15:0], c);
            default: begin
                $display("Unknown command %0d in the test table", op);
                error_count++;
            end
        endcase
    endtask

    initial begin
        int fd;
        int code;
        int fields;
        int op;
        int sva_fails;
        int commands;
        logic [1023:0] line;
        logic [31:0] arg_a;
        logic [31:0] arg_b;
        logic [31:0] arg_c;
        reset = 1'b1;
        bus_req = '0;
        status = '0;
        phy_int = 1'b0;
        commands = 0;
        repeat (16) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        if ({bus_rsp.aw_ready, bus_rsp.w_ready, bus_rsp.ar_ready} !== 3'b111) begin
            $display("[ERROR] %0t: aw/w/ar_ready = %b, expected 111", $time,
                     {bus_rsp.aw_ready, bus_rsp.w_ready, bus_rsp.ar_ready});
            error_count++;
        end
        if ({bus_rsp.r_valid, bus_rsp.b_valid} !== 2'b00) begin
            $display("[ERROR] %0t: r_valid/b_valid = %b, expected 00", $time,
                     {bus_rsp.r_valid, bus_rsp.b_valid});
            error_count++;
        end
        if ({mdc, mdio_oe, mdio_out} !== 3'b001) begin
            $display("[ERROR] %0t: mdc_o/mdio_oe_o/mdio_o = %b, expected 001", $time,
                     {mdc, mdio_oe, mdio_out});
            error_count++;
        end

        fd = $fopen("tb/eth_mgmt_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tb/eth_mgmt_tests.txt");
            error_count++;
        end else begin
            // Comment and blank lines fail the scan and are skipped
            while (!$feof(fd)) begin
                line = '0;
                code = $fgets(line, fd);
                fields = $sscanf(line, "%h %h %h %h", op, arg_a, arg_b, arg_c);
                if (code > 0 && fields == 4) begin
                    run_command(op, arg_a, arg_b, arg_c);
                    commands++;
                end
            end
            $fclose(fd);
            if (commands == 0) begin
                $display("No test commands were read from tb/eth_mgmt_tests.txt");
                error_count++;
            end
        end

        sva_fails = eth_mgmt_top_i.eth_mgmt_sva_i.fail_count;
        $display("Errors: %0d, timeouts: %0d, assertion failures: %0d", error_count,
                 timeout_count, sva_fails);
        if (error_count == 0 && timeout_count == 0 && sva_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/eth_mgmt_tests.txt ====
# op arg_a arg_b arg_c, all hex; 1 write addr data, 2 read addr expected, 3 status word
# 4 phy_int level, 5 irq expected, 6 phy_reset expected, 7 mdio frame reply expected_rx
# Reset values
2 000 00000000 0
2 008 00000000 0
2 00c 00010000 0
2 020 00000000 0
6 1 0 0
5 0 0 0
2 004 00000000 0
2 100 00000000 0
# Read back, PHY reset release, status word
1 008 a5a5f00f 0
2 008 a5a5f00f 0
1 020 00000001 0
6 0 0 0
2 020 00000001 0
1 020 fffffffe 0
6 1 0 0
2 020 00000000 0
1 100 ffffffff 0
2 100 00000000 0
3 8421 0 0
2 000 00008421 0
2 00c 00018421 0
# Interrupt masks
1 008 00000001 0
5 1 0 0
1 008 00000002 0
5 0 0 0
3 8423 0 0
5 1 0 0
3 0000 0 0
5 0 0 0
1 008 00010000 0
5 1 0 0
1 008 00020000 0
5 0 0 0
4 1 0 0
5 1 0 0
2 00c 00030000 0
4 0 0 0
5 0 0 0
1 008 fffcffff 0
4 1 0 0
5 0 0 0
3 0010 0 0
5 1 0 0
3 0000 0 0
4 0 0 0
1 008 00000000 0
5 0 0 0
# MDIO write frame, then two read frames
1 020 00000001 0
7 5192beef 0000 5192beef
2 024 5192beef 0
2 00c 00010000 0
7 61871234 796d 6186796d
7 6ffc0000 a5c3 6ffea5c3
2 028 6ffea5c3 0
